// File: verilog/audio_pkg.sv
/*
 * Audio sample definitions
 * Sample format, channel count and the per-channel calibration
 * coefficients for the four inputs and four outputs
 */

package audio_pkg;

    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam int N_CH = 4;

    // Gain is a fixed point fraction, 16384 is unity
    localparam int CAL_SHIFT = 14;

    // Input side, applied after the sign flip of the frontend
    localparam sample_t in_offset [N_CH] = '{16'sd0, 16'sd120, -16'sd80, 16'sd40};
    localparam sample_t in_gain [N_CH] = '{16'sd16384, 16'sd16800, 16'sd15900, 16'sd16384};

    // Output side, offset added after scaling
    localparam sample_t out_offset [N_CH] = '{16'sd25, -16'sd60, 16'sd90, 16'sd0};
    localparam sample_t out_gain [N_CH] = '{16'sd16384, 16'sd16100, 16'sd16650, 16'sd16384};

    // Saturation limits
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = -16'sh8000;

endpackage

// File: verilog/codec_pkg.sv
/*
 * TDM codec port geometry
 * Slot and frame sizes of the serial audio link and the
 * sync byte that opens every UART sample packet
 */

package codec_pkg;

    // Bit clock periods per TDM slot
    localparam int SLOT_BITS = 32;

    // Significant bits per slot, MSB first, rest is padding
    localparam int SAMPLE_BITS = 16;

    localparam int FRAME_SLOTS = 4;

    // First byte of each UART packet
    localparam logic [7:0] UART_SYNC = 8'hA5;

endpackage

// File: verilog/sample_bus_if.sv
/*
 * Sample bus
 * One strobe with four signed samples, valid while strobe is high
 * and held until the next strobe
 */

`timescale 1ns/1ps

interface sample_bus_if;

    logic strobe;
    audio_pkg::sample_t ch0;
    audio_pkg::sample_t ch1;
    audio_pkg::sample_t ch2;
    audio_pkg::sample_t ch3;

    modport source (
        output strobe, ch0, ch1, ch2, ch3
    );

    modport sink (
        input strobe, ch0, ch1, ch2, ch3
    );

endinterface

// File: verilog/tdm_codec_port.sv
/*
 * TDM codec port
 * Generates bick and lrck, collects four ADC slots from sdout and
 * shifts the latched DAC words out on sdin
 */

`timescale 1ns/1ps

module tdm_codec_port #(
    parameter int BICK_DIV = 2
) (
    input  logic         clk,
    input  logic         rst,
    output logic         bick,
    output logic         lrck,
    input  logic         sdout,
    output logic         sdin,
    sample_bus_if.source adc,
    sample_bus_if.sink   dac
);

    localparam int FRAME_BITS = codec_pkg::SLOT_BITS * codec_pkg::FRAME_SLOTS;
    localparam int CNT_W = $clog2(FRAME_BITS);
    localparam int POS_W = $clog2(codec_pkg::SLOT_BITS);
    localparam int SLOT_W = CNT_W - POS_W;
    localparam int DIV_W = $clog2(BICK_DIV + 1);
    localparam int SW = audio_pkg::SAMPLE_W;

    logic [DIV_W-1:0] div_cnt;
    logic tick;
    logic rise;
    logic fall;
    logic frame_end;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] next_cnt;
    logic [POS_W-1:0] pos;
    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] next_slot;
    logic framed;
    logic dac_seen;
    logic strobe;
    audio_pkg::sample_t rx_shift;
    audio_pkg::sample_t tx_shift;
    audio_pkg::sample_t rx_word [codec_pkg::FRAME_SLOTS];
    audio_pkg::sample_t adc_word [codec_pkg::FRAME_SLOTS];
    audio_pkg::sample_t tx_word [codec_pkg::FRAME_SLOTS];

    assign tick = (div_cnt == DIV_W'(BICK_DIV - 1));
    assign rise = tick && !bick;
    assign fall = tick && bick;

    // Frame length is a power of two, so the counter wraps by itself
    assign next_cnt = bit_cnt + 1'b1;
    assign pos = bit_cnt[POS_W-1:0];
    assign slot = bit_cnt[CNT_W-1:POS_W];
    assign next_slot = next_cnt[CNT_W-1:POS_W];

    // Last bit of slot 3 sampled, only once a whole frame has run
    assign frame_end = rise && (bit_cnt == '1) && framed;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            bick <= 1'b0;
            lrck <= 1'b0;
            sdin <= 1'b0;
            bit_cnt <= '1;
            framed <= 1'b0;
            dac_seen <= 1'b0;
            strobe <= 1'b0;
            tx_shift <= '0;
            tx_word <= '{default: '0};
        end else begin
            strobe <= frame_end;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                bick <= ~bick;
            end
            if (dac.strobe) begin
                dac_seen <= 1'b1;
            end
            // Words for the next frame, zeros until the DAC path has run once
            if (frame_end && dac_seen) begin
                tx_word[0] <= dac.ch0;
                tx_word[1] <= dac.ch1;
                tx_word[2] <= dac.ch2;
                tx_word[3] <= dac.ch3;
            end
            if (fall) begin
                bit_cnt <= next_cnt;
                lrck <= (next_slot == '0);
                if (next_cnt == '0) begin
                    framed <= 1'b1;
                end
                // Load at slot start, padding falls out as shifted-in zeros
                if (next_cnt[POS_W-1:0] == '0) begin
                    sdin <= tx_word[next_slot][SW-1];
                    tx_shift <= tx_word[next_slot] << 1;
                end else begin
                    sdin <= tx_shift[SW-1];
                    tx_shift <= tx_shift << 1;
                end
            end
        end
    end

    // ADC capture on the rising bick edge
    always_ff @(posedge clk) begin
        if (rise && (pos < codec_pkg::SAMPLE_BITS)) begin
            rx_shift <= {rx_shift[SW-2:0], sdout};
            if (pos == POS_W'(codec_pkg::SAMPLE_BITS - 1)) begin
                rx_word[slot] <= {rx_shift[SW-2:0], sdout};
            end
        end
        if (frame_end) begin
            adc_word <= rx_word;
        end
    end

    assign adc.strobe = strobe;
    assign adc.ch0 = adc_word[0];
    assign adc.ch1 = adc_word[1];
    assign adc.ch2 = adc_word[2];
    assign adc.ch3 = adc_word[3];

endmodule

// File: verilog/channel_cal.sv
/*
 * Channel calibration
 * One shared multiplier corrects offset and gain of the four inputs
 * and the four outputs, two cycles per channel, with saturation
 */

`timescale 1ns/1ps

module channel_cal (
    input  logic         clk,
    input  logic         rst,
    sample_bus_if.sink   raw_in,
    sample_bus_if.source cal_in,
    sample_bus_if.sink   core_out,
    sample_bus_if.source dac_out
);

    localparam int SW = audio_pkg::SAMPLE_W;
    localparam int OP_W = SW + 2;
    localparam int PROD_W = OP_W + SW;
    localparam int SCALE_W = PROD_W - audio_pkg::CAL_SHIFT;
    localparam int SUM_W = SCALE_W + 1;
    localparam int CH_W = $clog2(audio_pkg::N_CH);
    localparam logic [CH_W-1:0] LAST_CH = CH_W'(audio_pkg::N_CH - 1);

    logic busy;
    logic out_job;
    logic sat_step;
    logic done_in;
    logic done_out;
    logic [CH_W-1:0] ch;
    audio_pkg::sample_t raw_x;
    audio_pkg::sample_t core_x;
    audio_pkg::sample_t mul_b;
    audio_pkg::sample_t post_off;
    audio_pkg::sample_t sat_val;
    logic signed [OP_W-1:0] x_ext;
    logic signed [OP_W-1:0] off_ext;
    logic signed [OP_W-1:0] mul_a;
    logic signed [PROD_W-1:0] prod;
    logic signed [SCALE_W-1:0] scaled;
    logic signed [SUM_W-1:0] sum;
    audio_pkg::sample_t stage [audio_pkg::N_CH-1];
    audio_pkg::sample_t in_res [audio_pkg::N_CH];
    audio_pkg::sample_t out_res [audio_pkg::N_CH];

    always_comb begin
        case (ch)
            2'd0: begin
                raw_x = raw_in.ch0;
                core_x = core_out.ch0;
            end
            2'd1: begin
                raw_x = raw_in.ch1;
                core_x = core_out.ch1;
            end
            2'd2: begin
                raw_x = raw_in.ch2;
                core_x = core_out.ch2;
            end
            default: begin
                raw_x = raw_in.ch3;
                core_x = core_out.ch3;
            end
        endcase
    end

    // Operand select for the shared multiplier
    always_comb begin
        if (out_job) begin
            x_ext = core_x;
            off_ext = '0;
            mul_b = audio_pkg::out_gain[ch];
            post_off = audio_pkg::out_offset[ch];
        end else begin
            x_ext = raw_x;
            off_ext = audio_pkg::in_offset[ch];
            mul_b = audio_pkg::in_gain[ch];
            post_off = 16'sd0;
        end
        // Frontend inverts the input, flip it back before the offset
        mul_a = out_job ? x_ext : -x_ext - off_ext;
    end

    assign scaled = prod[PROD_W-1:audio_pkg::CAL_SHIFT];
    assign sum = scaled + post_off;

    always_comb begin
        if (sum > audio_pkg::SAMPLE_MAX) begin
            sat_val = audio_pkg::SAMPLE_MAX;
        end else if (sum < audio_pkg::SAMPLE_MIN) begin
            sat_val = audio_pkg::SAMPLE_MIN;
        end else begin
            sat_val = sum[SW-1:0];
        end
    end

    // Sequencer, input job has priority
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            out_job <= 1'b0;
            sat_step <= 1'b0;
            ch <= '0;
            done_in <= 1'b0;
            done_out <= 1'b0;
        end else begin
            done_in <= 1'b0;
            done_out <= 1'b0;
            if (!busy) begin
                if (raw_in.strobe || core_out.strobe) begin
                    busy <= 1'b1;
                    out_job <= !raw_in.strobe;
                    sat_step <= 1'b0;
                    ch <= '0;
                end
            end else if (!sat_step) begin
                sat_step <= 1'b1;
            end else begin
                sat_step <= 1'b0;
                ch <= ch + 1'b1;
                if (ch == LAST_CH) begin
                    busy <= 1'b0;
                    done_in <= !out_job;
                    done_out <= out_job;
                end
            end
        end
    end

    // Results go out together so the bus holds steady between strobes
    always_ff @(posedge clk) begin
        if (busy && !sat_step) begin
            prod <= mul_a * mul_b;
        end
        if (busy && sat_step) begin
            if (ch != LAST_CH) begin
                stage[ch] <= sat_val;
            end else if (out_job) begin
                out_res[0:2] <= stage;
                out_res[3] <= sat_val;
            end else begin
                in_res[0:2] <= stage;
                in_res[3] <= sat_val;
            end
        end
    end

    assign cal_in.strobe = done_in;
    assign cal_in.ch0 = in_res[0];
    assign cal_in.ch1 = in_res[1];
    assign cal_in.ch2 = in_res[2];
    assign cal_in.ch3 = in_res[3];

    assign dac_out.strobe = done_out;
    assign dac_out.ch0 = out_res[0];
    assign dac_out.ch1 = out_res[1];
    assign dac_out.ch2 = out_res[2];
    assign dac_out.ch3 = out_res[3];

endmodule

// File: verilog/vca_core.sv
/*
 * VCA core
 * Channel 0 is scaled by the positive part of channel 1,
 * channels 1 to 3 pass through, one cycle of latency
 */

`timescale 1ns/1ps

module vca_core (
    input  logic         clk,
    input  logic         rst,
    sample_bus_if.sink   in,
    sample_bus_if.source out
);

    localparam int SW = audio_pkg::SAMPLE_W;
    localparam int PROD_W = 2 * SW;

    audio_pkg::sample_t ctrl;
    logic signed [PROD_W-1:0] prod;
    logic strobe;
    audio_pkg::sample_t ch0_q;
    audio_pkg::sample_t ch1_q;
    audio_pkg::sample_t ch2_q;
    audio_pkg::sample_t ch3_q;

    // Negative control closes the amplifier
    assign ctrl = in.ch1[SW-1] ? 16'sd0 : in.ch1;
    assign prod = in.ch0 * ctrl;

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe <= 1'b0;
        end else begin
            strobe <= in.strobe;
        end
    end

    // Control is never negative, so the product fits in 31 bits
    always_ff @(posedge clk) begin
        if (in.strobe) begin
            ch0_q <= prod[PROD_W-2 -: SW];
            ch1_q <= in.ch1;
            ch2_q <= in.ch2;
            ch3_q <= in.ch3;
        end
    end

    assign out.strobe = strobe;
    assign out.ch0 = ch0_q;
    assign out.ch1 = ch1_q;
    assign out.ch2 = ch2_q;
    assign out.ch3 = ch3_q;

endmodule

// File: verilog/sample_uart.sv
/*
 * Sample UART
 * Sends each raw ADC frame as a sync byte and four 16-bit words,
 * high byte first, in 8N1 format
 */

`timescale 1ns/1ps

module sample_uart #(
    parameter int UART_DIV = 4
) (
    input  logic       clk,
    input  logic       rst,
    sample_bus_if.sink raw,
    output logic       tx
);

    localparam int SW = audio_pkg::SAMPLE_W;
    localparam int N_BYTES = 1 + 2 * audio_pkg::N_CH;
    localparam int BUF_W = SW * audio_pkg::N_CH;
    localparam int FRAME_W = 10;
    localparam int DIV_W = $clog2(UART_DIV + 1);
    localparam int BYTE_W = $clog2(N_BYTES);
    localparam int BIT_W = $clog2(FRAME_W);

    logic busy;
    logic start;
    logic bit_end;
    logic byte_end;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_idx;
    logic [BYTE_W-1:0] byte_idx;
    logic [FRAME_W-1:0] shifter;
    logic [BUF_W-1:0] frame_buf;

    // Frames arriving mid-packet are dropped
    assign start = raw.strobe && !busy;
    assign bit_end = busy && (div_cnt == DIV_W'(UART_DIV - 1));
    assign byte_end = bit_end && (bit_idx == BIT_W'(FRAME_W - 1));

    // Idle shifter is all ones
    assign tx = shifter[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            div_cnt <= '0;
            bit_idx <= '0;
            byte_idx <= '0;
            shifter <= '1;
        end else if (start) begin
            busy <= 1'b1;
            div_cnt <= '0;
            bit_idx <= '0;
            byte_idx <= '0;
            shifter <= {1'b1, codec_pkg::UART_SYNC, 1'b0};
        end else if (busy) begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (byte_end) begin
                bit_idx <= '0;
                if (byte_idx == BYTE_W'(N_BYTES - 1)) begin
                    busy <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    shifter <= {1'b1, frame_buf[BUF_W-1 -: 8], 1'b0};
                end
            end else if (bit_end) begin
                bit_idx <= bit_idx + 1'b1;
                shifter <= {1'b1, shifter[FRAME_W-1:1]};
            end
        end
    end

    // Packed words, next byte always at the top
    always_ff @(posedge clk) begin
        if (start) begin
            frame_buf <= {raw.ch0, raw.ch1, raw.ch2, raw.ch3};
        end else if (byte_end) begin
            frame_buf <= frame_buf << 8;
        end
    end

endmodule

// File: verilog/eurorack_top.sv
/*
 * Eurorack audio path
 * Codec port, input and output calibration around the VCA core,
 * and a UART stream of the raw ADC frames
 */

`timescale 1ns/1ps

module eurorack_top #(
    parameter int BICK_DIV = 2,
    parameter int UART_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic sdout,
    output logic bick,
    output logic lrck,
    output logic sdin,
    output logic tx
);

    // Raw samples from the codec
    sample_bus_if adc_bus ();
    // Calibrated inputs into the core
    sample_bus_if cal_in_bus ();
    sample_bus_if core_bus ();
    // Calibrated outputs to the codec
    sample_bus_if dac_bus ();

    tdm_codec_port #(
        .BICK_DIV (BICK_DIV)
    ) codec_port_instance (
        .clk   (clk),
        .rst   (rst),
        .bick  (bick),
        .lrck  (lrck),
        .sdout (sdout),
        .sdin  (sdin),
        .adc   (adc_bus.source),
        .dac   (dac_bus.sink)
    );

    channel_cal cal_instance (
        .clk      (clk),
        .rst      (rst),
        .raw_in   (adc_bus.sink),
        .cal_in   (cal_in_bus.source),
        .core_out (core_bus.sink),
        .dac_out  (dac_bus.source)
    );

    vca_core vca_instance (
        .clk (clk),
        .rst (rst),
        .in  (cal_in_bus.sink),
        .out (core_bus.source)
    );

    // UART sees the samples before calibration
    sample_uart #(
        .UART_DIV (UART_DIV)
    ) uart_instance (
        .clk (clk),
        .rst (rst),
        .raw (adc_bus.sink),
        .tx  (tx)
    );

endmodule

// File: tb/eurorack_properties.sv
/*
 * Bound checks for the codec port and the sample UART
 * Single-cycle ADC and DAC strobes, lrck rising on slot 0, tx high while idle
 */

`timescale 1ns/1ps

module eurorack_properties (
    input logic clk,
    input logic rst,
    input logic strobe,
    input logic lrck,
    input logic frame_start,
    input logic tx,
    input logic idle
);

    int failures = 0;

    // A frame strobe lasts one clk cycle
    strobe_single: assert property (@(posedge clk) disable iff (rst) strobe |=> !strobe)
        else begin
            failures++;
            $error("strobe high for two cycles in a row");
        end

    lrck_at_slot0: assert property (@(posedge clk) disable iff (rst) $rose(lrck) |-> frame_start)
        else begin
            failures++;
            $error("lrck rose away from a slot 0 boundary");
        end

    tx_idle_high: assert property (@(posedge clk) disable iff (rst) idle |-> tx)
        else begin
            failures++;
            $error("tx low while the UART is idle");
        end

endmodule

bind tdm_codec_port eurorack_properties codec_checks (
    .clk         (clk),
    .rst         (rst),
    .strobe      (dac.strobe),
    .lrck        (lrck),
    .frame_start (bit_cnt == 0),
    .tx          (1'b1),
    .idle        (1'b1)
);

bind sample_uart eurorack_properties uart_checks (
    .clk         (clk),
    .rst         (rst),
    .strobe      (raw.strobe),
    .lrck        (1'b0),
    .frame_start (1'b1),
    .tx          (tx),
    .idle        (!busy)
);

// File: tb/eurorack_tb.sv
/*
 * Testbench for the eurorack audio path
 * Codec model driven from a trace file, UART receiver, checks on
 * DAC frames, UART packets and frame geometry
 */

`timescale 1ns/1ps

module eurorack_tb;

    localparam int BICK_DIV = 2;
    localparam int UART_DIV = 4;
    localparam int MAX_FRAMES = 64;
    localparam int FRAME_CYCLES = 512;
    localparam int SLOT_BITS = codec_pkg::SLOT_BITS;
    localparam int SAMPLE_BITS = codec_pkg::SAMPLE_BITS;
    localparam int FRAME_SLOTS = codec_pkg::FRAME_SLOTS;
    localparam int FRAME_BITS = SLOT_BITS * FRAME_SLOTS;
    localparam int PACKET_BYTES = 9;

    logic clk = 1'b0;
    logic rst;
    logic sdout;
    logic bick;
    logic lrck;
    logic sdin;
    logic tx;

    logic [15:0] adc_tr [MAX_FRAMES][4];
    logic [15:0] dac_tr [MAX_FRAMES][4];
    int n_frames = 0;
    int cycle_limit = 0;
    int cycle_count = 0;
    int error_count = 0;

    // Codec model position, frame -1 is before the first lrck
    int frame_idx = -1;
    int bit_idx = 0;
    int frame_bits = 0;
    int lrck_bits = 0;
    int dac_checked = 0;
    int rx_count = 0;
    logic prev_bick = 1'b0;
    logic prev_lrck = 1'b0;
    logic [15:0] dac_shift = '0;
    logic [7:0] rx_byte;

    eurorack_top #(
        .BICK_DIV (BICK_DIV),
        .UART_DIV (UART_DIV)
    ) UUT (
        .clk   (clk),
        .rst   (rst),
        .sdout (sdout),
        .bick  (bick),
        .lrck  (lrck),
        .sdin  (sdin),
        .tx    (tx)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic read_trace();
        int fd;
        int n;
        string line;
        logic [15:0] v [8];
        fd = $fopen("tb/eurorack_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tb/eurorack_trace.txt");
            $display("Errors found");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd) && n_frames < MAX_FRAMES) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (n == 8) begin
                        for (int i = 0; i < 4; i++) begin
                            adc_tr[n_frames][i] = v[i];
                            dac_tr[n_frames][i] = v[i + 4];
                        end
                        n_frames++;
                    end
                end
            end
            $fclose(fd);
            if (n_frames == 0) begin
                $display("the trace file holds no frames");
                $display("Errors found");
                $fatal(1, "empty trace");
            end
        end
    endtask

    // Called after bick falls, sets sdout for the new bit
    task automatic advance_bit();
        int slot;
        int pos;
        if (lrck && !prev_lrck) begin
            if (frame_idx >= 0) begin
                check_value("bick periods per frame", frame_bits, FRAME_BITS);
                check_value("lrck high periods per frame", lrck_bits, SLOT_BITS);
            end
            frame_idx++;
            bit_idx = 0;
            frame_bits = 0;
            lrck_bits = 0;
        end else begin
            bit_idx++;
        end
        frame_bits++;
        if (lrck) begin
            lrck_bits++;
        end
        slot = bit_idx / SLOT_BITS;
        pos = bit_idx % SLOT_BITS;
        if (frame_idx >= 0 && frame_idx < n_frames && slot < FRAME_SLOTS && pos < SAMPLE_BITS) begin
            sdout <= adc_tr[frame_idx][slot][SAMPLE_BITS - 1 - pos];
        end else begin
            sdout <= 1'b0;
        end
    endtask

    // Called after bick rises, sdin is stable since the fall
    task automatic capture_dac_bit();
        int slot;
        int pos;
        int src;
        slot = bit_idx / SLOT_BITS;
        pos = bit_idx % SLOT_BITS;
        src = frame_idx - 2;
        if (frame_idx < 2) begin
            check_value("sdin before the first DAC frame", sdin, 1'b0);
        end else if (pos >= SAMPLE_BITS) begin
            check_value("sdin slot padding", sdin, 1'b0);
        end else begin
            dac_shift = {dac_shift[14:0], sdin};
            if (pos == SAMPLE_BITS - 1 && src < n_frames && slot < FRAME_SLOTS) begin
                check_value($sformatf("sdin ch%0d of trace frame %0d", slot, src),
                            dac_shift, dac_tr[src][slot]);
                if (slot == FRAME_SLOTS - 1) begin
                    dac_checked++;
                end
            end
        end
    endtask

    task automatic receive_byte(output logic [7:0] data);
        int i;
        do begin
            @(negedge clk);
        end while (tx !== 1'b0);
        // On to the middle of the start bit
        repeat (UART_DIV / 2 - 1) @(negedge clk);
        check_value("uart start bit", tx, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (UART_DIV) @(negedge clk);
            data[i] = tx;
        end
        repeat (UART_DIV) @(negedge clk);
        check_value("uart stop bit", tx, 1'b1);
    endtask

    task automatic check_uart_byte(input logic [7:0] data);
        int pkt;
        int idx;
        logic [15:0] word;
        logic [7:0] expected;
        pkt = rx_count / PACKET_BYTES;
        idx = rx_count % PACKET_BYTES;
        if (pkt < n_frames) begin
            if (idx == 0) begin
                expected = codec_pkg::UART_SYNC;
            end else begin
                word = adc_tr[pkt][(idx - 1) / 2];
                expected = ((idx - 1) % 2 == 0) ? word[15:8] : word[7:0];
            end
            check_value($sformatf("uart byte %0d of packet %0d", idx, pkt), data, expected);
        end
        rx_count++;
    endtask

    // Codec model, inputs change on the falling clk edge
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_bick && !bick) begin
                advance_bit();
            end
            if (!prev_bick && bick) begin
                capture_dac_bit();
            end
            if (frame_idx < 0 || (frame_idx == 0 && bit_idx < FRAME_BITS - 1)) begin
                check_value("tx before the first packet", tx, 1'b1);
            end
        end
        prev_bick = bick;
        prev_lrck = lrck;
    end

    initial begin
        @(posedge clk);
        wait (rst == 1'b0);
        forever begin
            receive_byte(rx_byte);
            check_uart_byte(rx_byte);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stalled before all DAC frames came out",
                     cycle_count);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst = 1'b1;
        sdout = 1'b0;
        read_trace();
        // Two frames of latency plus margin
        cycle_limit = (n_frames + 4) * FRAME_CYCLES * 2;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait (dac_checked == n_frames);
        @(negedge clk);
        check_value("uart bytes received", rx_count >= PACKET_BYTES * n_frames, 1'b1);
        check_value("assertion failures",
                    UUT.codec_port_instance.codec_checks.failures +
                    UUT.uart_instance.uart_checks.failures, 0);
        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "run ended with failed checks");
        end
    end

endmodule

// File: eurorack_pmod.f
verilog/audio_pkg.sv
verilog/codec_pkg.sv
verilog/sample_bus_if.sv
verilog/tdm_codec_port.sv
verilog/channel_cal.sv
verilog/vca_core.sv
verilog/sample_uart.sv
verilog/eurorack_top.sv
tb/eurorack_properties.sv
tb/eurorack_tb.sv

// File: tb/eurorack_trace.txt
# adc0 adc1 adc2 adc3 are the raw codec words sent on sdout in frame n
# dac0 dac1 dac2 dac3 are the words expected on sdin in frame n+2, all hex
# Silence, only the calibration offsets come through
0000 0000 0000 0000  0019 ff4a 00a8 ffd8
# Control near half scale, exact gain steps on channels 1 and 2
c000 bf88 f050 03e8  20e9 4040 1021 fbf0
# Negative control closes the VCA
3039 1388 2050 8000  0019 eb9d e0ca 7fd8
# Full scale inputs clamp before and after the core
8000 8000 7fff 7fff  7fff 7d8b 826c 8000
# Negative full scale signal with full control
7fff 8000 fc18 ffff  801a 7d8b 0483 ffd9
# Control clamps to the negative limit
0064 7fff 0050 7fd7  0019 81fc 005a 8001
# Small control, product rounds down
f830 fd88 b1e0 3039  0039 01c7 4db4 cf9f
# Negative signal, floor goes below zero
07d0 fd88 f050 0000  fff8 01c7 1021 ffd8
